/* riscvPkg.sv */
package riscvPkg;

    // major opcodes in instr bits 6:0
    localparam logic [6:0] opR      = 7'b0110011;   // register-register alu
    localparam logic [6:0] opI      = 7'b0010011;   // register-immediate alu
    localparam logic [6:0] opLoad   = 7'b0000011;   // lb lh lw lbu lhu
    localparam logic [6:0] opStore  = 7'b0100011;   // sb sh sw
    localparam logic [6:0] opBranch = 7'b1100011;   // beq bne blt bge bltu bgeu
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;

    // main decoder to alu decoder
    localparam logic [2:0] aluOpR      = 3'b000;
    localparam logic [2:0] aluOpI      = 3'b001;
    localparam logic [2:0] aluOpLoad   = 3'b010;
    localparam logic [2:0] aluOpStore  = 3'b011;
    localparam logic [2:0] aluOpBranch = 3'b100;
    localparam logic [2:0] aluOpJump   = 3'b101;   // shared by jal and jalr
    localparam logic [2:0] aluOpLui    = 3'b110;
    localparam logic [2:0] aluOpAuipc  = 3'b111;

    // immediate formats
    localparam logic [2:0] immI = 3'b000;
    localparam logic [2:0] immS = 3'b001;
    localparam logic [2:0] immB = 3'b010;
    localparam logic [2:0] immU = 3'b011;
    localparam logic [2:0] immJ = 3'b100;

    // writeback source select
    localparam logic [1:0] resAlu   = 2'b00;
    localparam logic [1:0] resMem   = 2'b01;
    localparam logic [1:0] resPc4   = 2'b10;   // link address
    localparam logic [1:0] resAuipc = 2'b11;   // pc + imm

    // concrete alu operations
    localparam logic [3:0] aluAdd   = 4'd0;
    localparam logic [3:0] aluSub   = 4'd1;
    localparam logic [3:0] aluAnd   = 4'd2;
    localparam logic [3:0] aluOr    = 4'd3;
    localparam logic [3:0] aluXor   = 4'd4;
    localparam logic [3:0] aluSll   = 4'd5;
    localparam logic [3:0] aluSrl   = 4'd6;
    localparam logic [3:0] aluSra   = 4'd7;
    localparam logic [3:0] aluSlt   = 4'd8;
    localparam logic [3:0] aluSltu  = 4'd9;
    localparam logic [3:0] aluPassB = 4'd10;   // lui result is the immediate

endpackage

/* control.sv */
module control
    import riscvPkg::*;
(
    input  logic [6:0] opcode,       // instr 6:0
    output logic       regWriteD,
    output logic [1:0] resultSrcD,   // alu, mem, pc+4 or auipc
    output logic       memWriteD,
    output logic       aluSrcD,      // 1 selects immediate as operand b
    output logic [2:0] immSrcD,
    output logic [2:0] aluOpD,
    output logic       jalrD,
    output logic       jumpD,        // jal or jalr, resolved in execute
    output logic       branchD
);

    always_comb begin
        // everything low unless the opcode says otherwise
        regWriteD  = 1'b0;
        resultSrcD = resAlu;
        memWriteD  = 1'b0;
        aluSrcD    = 1'b0;
        immSrcD    = immI;
        aluOpD     = aluOpR;
        jalrD      = 1'b0;
        jumpD      = 1'b0;
        branchD    = 1'b0;

        case (opcode)
            opR: begin
                regWriteD = 1'b1;       // rs1 op rs2
                aluOpD    = aluOpR;
            end
            opI: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;       // rs1 op imm
                immSrcD   = immI;
                aluOpD    = aluOpI;
            end
            opLoad: begin
                regWriteD  = 1'b1;
                resultSrcD = resMem;    // data from memory stage
                aluSrcD    = 1'b1;      // address = rs1 + imm
                immSrcD    = immI;
                aluOpD     = aluOpLoad;
            end
            opStore: begin
                memWriteD = 1'b1;       // only writer of memory
                aluSrcD   = 1'b1;
                immSrcD   = immS;
                aluOpD    = aluOpStore;
            end
            opBranch: begin
                immSrcD = immB;         // compares two regs so aluSrc stays 0
                aluOpD  = aluOpBranch;
                branchD = 1'b1;
            end
            opJal: begin
                regWriteD  = 1'b1;
                resultSrcD = resPc4;    // link
                aluSrcD    = 1'b1;
                immSrcD    = immJ;
                aluOpD     = aluOpJump;
                jumpD      = 1'b1;
            end
            opJalr: begin
                regWriteD  = 1'b1;
                resultSrcD = resPc4;
                aluSrcD    = 1'b1;      // target = rs1 + imm
                immSrcD    = immI;
                aluOpD     = aluOpJump;
                jalrD      = 1'b1;
                jumpD      = 1'b1;
            end
            opLui: begin
                regWriteD  = 1'b1;
                resultSrcD = resAlu;    // alu passes imm through
                aluSrcD    = 1'b1;
                immSrcD    = immU;
                aluOpD     = aluOpLui;
            end
            opAuipc: begin
                regWriteD  = 1'b1;
                resultSrcD = resAuipc;  // execute adds pc to imm
                aluSrcD    = 1'b1;
                immSrcD    = immU;
                aluOpD     = aluOpAuipc;
            end
            default: begin
                regWriteD = 1'b0;       // unknown opcode does nothing
            end
        endcase
    end

endmodule

/* aluDecoder.sv */
module aluDecoder
    import riscvPkg::*;
(
    input  logic [2:0] aluOp,
    input  logic [2:0] funct3,
    input  logic       funct7b5,     // instr 30
    input  logic       opb5,         // instr 5 is set for r-type
    output logic [3:0] aluControl
);

    logic subSel;   // sub only for r-type since addi has no sub form

    assign subSel = funct7b5 & opb5;

    always_comb begin
        aluControl = aluAdd;
        case (aluOp)
            aluOpLoad,
            aluOpStore,
            aluOpJump,
            aluOpAuipc: aluControl = aluAdd;    // address or pc-relative sum
            aluOpLui:   aluControl = aluPassB;  // imm straight through
            aluOpBranch: begin
                case (funct3)
                    3'b000,
                    3'b001:  aluControl = aluSub;   // beq bne on zero flag
                    3'b100,
                    3'b101:  aluControl = aluSlt;   // blt bge
                    3'b110,
                    3'b111:  aluControl = aluSltu;  // bltu bgeu
                    default: aluControl = aluSub;   // reserved encodings
                endcase
            end
            aluOpR,
            aluOpI: begin
                case (funct3)
                    3'b000:  aluControl = subSel ? aluSub : aluAdd;
                    3'b001:  aluControl = aluSll;
                    3'b010:  aluControl = aluSlt;
                    3'b011:  aluControl = aluSltu;
                    3'b100:  aluControl = aluXor;
                    3'b101:  aluControl = funct7b5 ? aluSra : aluSrl;  // srai too
                    3'b110:  aluControl = aluOr;
                    3'b111:  aluControl = aluAnd;
                    default: aluControl = aluAdd;
                endcase
            end
            default: aluControl = aluAdd;
        endcase
    end

endmodule

/* immExtend.sv */
module immExtend
    import riscvPkg::*;
#(
    parameter int dataWidth = 32
) (
    input  logic [31:7]          instr,    // opcode bits not needed
    input  logic [2:0]           immSrc,
    output logic [dataWidth-1:0] immExt
);

    logic signBit;

    assign signBit = instr[31];   // every format takes its sign here

    always_comb begin
        case (immSrc)
            // 12 bit for loads, alu imm and jalr
            immI: immExt = {{(dataWidth-12){signBit}}, instr[31:20]};
            // 12 bit split around rd field
            immS: immExt = {{(dataWidth-12){signBit}}, instr[31:25], instr[11:7]};
            // 13 bit with lsb always zero
            immB: immExt = {{(dataWidth-12){signBit}}, instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            // upper 20 bits with low 12 zero
            immU: immExt = {{(dataWidth-31){signBit}}, instr[30:12], 12'b0};
            // 21 bit jump offset
            immJ: immExt = {{(dataWidth-20){signBit}}, instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            default: immExt = '0;
        endcase
    end

endmodule

/* regFile.sv */
module regFile #(
    parameter int dataWidth    = 32,
    parameter int regAddrWidth = 5
) (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    we,     // writeback enable
    input  logic [regAddrWidth-1:0] wa,
    input  logic [dataWidth-1:0]    wd,
    input  logic [regAddrWidth-1:0] ra1,
    input  logic [regAddrWidth-1:0] ra2,
    output logic [dataWidth-1:0]    rd1,
    output logic [dataWidth-1:0]    rd2
);

    localparam int numRegs = 2 ** regAddrWidth;

    logic [dataWidth-1:0] regs [numRegs];

    // x0 reads zero and a same-cycle write is forwarded
    function automatic logic [dataWidth-1:0] readPort(input logic [regAddrWidth-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (we && (wa == addr)) begin
            return wd;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;   // x0 never written
        end
    end

    always_comb begin
        rd1 = readPort(ra1);
        rd2 = readPort(ra2);
    end

endmodule

/* decodeExecuteReg.sv */
module decodeExecuteReg
    import riscvPkg::*;
#(
    parameter int dataWidth    = 32,
    parameter int regAddrWidth = 5
) (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    flush,        // load a bubble next edge
    input  logic                    regWriteD,
    input  logic [1:0]              resultSrcD,
    input  logic                    memWriteD,
    input  logic                    aluSrcD,
    input  logic [3:0]              aluControlD,
    input  logic                    jalrD,
    input  logic                    jumpD,
    input  logic                    branchD,
    input  logic [2:0]              funct3D,      // branch compare type in execute
    input  logic [dataWidth-1:0]    rd1D,
    input  logic [dataWidth-1:0]    rd2D,
    input  logic [dataWidth-1:0]    immExtD,
    input  logic [dataWidth-1:0]    pcD,
    input  logic [dataWidth-1:0]    pcPlus4D,
    input  logic [regAddrWidth-1:0] rs1D,         // for forwarding
    input  logic [regAddrWidth-1:0] rs2D,
    input  logic [regAddrWidth-1:0] rdD,
    output logic                    regWriteE,
    output logic [1:0]              resultSrcE,
    output logic                    memWriteE,
    output logic                    aluSrcE,
    output logic [3:0]              aluControlE,
    output logic                    jalrE,
    output logic                    jumpE,
    output logic                    branchE,
    output logic [2:0]              funct3E,
    output logic [dataWidth-1:0]    rd1E,
    output logic [dataWidth-1:0]    rd2E,
    output logic [dataWidth-1:0]    immExtE,
    output logic [dataWidth-1:0]    pcE,
    output logic [dataWidth-1:0]    pcPlus4E,
    output logic [regAddrWidth-1:0] rs1E,
    output logic [regAddrWidth-1:0] rs2E,
    output logic [regAddrWidth-1:0] rdE
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteE   <= 1'b0;
            resultSrcE  <= resAlu;
            memWriteE   <= 1'b0;
            aluSrcE     <= 1'b0;
            aluControlE <= aluAdd;
            jalrE       <= 1'b0;
            jumpE       <= 1'b0;
            branchE     <= 1'b0;
            funct3E     <= '0;
            rd1E        <= '0;
            rd2E        <= '0;
            immExtE     <= '0;
            pcE         <= '0;
            pcPlus4E    <= '0;
            rs1E        <= '0;
            rs2E        <= '0;
            rdE         <= '0;
        end else begin
            // flush gives the same all-zero bubble as reset
            regWriteE   <= flush ? 1'b0 : regWriteD;
            resultSrcE  <= flush ? resAlu : resultSrcD;
            memWriteE   <= flush ? 1'b0 : memWriteD;   // no stray store
            aluSrcE     <= flush ? 1'b0 : aluSrcD;
            aluControlE <= flush ? aluAdd : aluControlD;
            jalrE       <= flush ? 1'b0 : jalrD;
            jumpE       <= flush ? 1'b0 : jumpD;       // no stray redirect
            branchE     <= flush ? 1'b0 : branchD;
            funct3E     <= flush ? '0 : funct3D;
            rd1E        <= flush ? '0 : rd1D;
            rd2E        <= flush ? '0 : rd2D;
            immExtE     <= flush ? '0 : immExtD;
            pcE         <= flush ? '0 : pcD;
            pcPlus4E    <= flush ? '0 : pcPlus4D;
            rs1E        <= flush ? '0 : rs1D;
            rs2E        <= flush ? '0 : rs2D;
            rdE         <= flush ? '0 : rdD;
        end
    end

endmodule

/* decodeStage.sv */
module decodeStage #(
    parameter int dataWidth    = 32,
    parameter int regAddrWidth = 5
) (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [31:0]             instrD,     // from fetch register
    input  logic [dataWidth-1:0]    pcD,
    input  logic [dataWidth-1:0]    pcPlus4D,
    input  logic                    flushE,     // from hazard unit
    input  logic                    regWriteW,  // writeback port
    input  logic [regAddrWidth-1:0] rdW,
    input  logic [dataWidth-1:0]    resultW,
    output logic                    regWriteE,
    output logic [1:0]              resultSrcE,
    output logic                    memWriteE,
    output logic                    aluSrcE,
    output logic [3:0]              aluControlE,
    output logic                    jalrE,
    output logic                    jumpE,
    output logic                    branchE,
    output logic [2:0]              funct3E,
    output logic [dataWidth-1:0]    rd1E,
    output logic [dataWidth-1:0]    rd2E,
    output logic [dataWidth-1:0]    immExtE,
    output logic [dataWidth-1:0]    pcE,
    output logic [dataWidth-1:0]    pcPlus4E,
    output logic [regAddrWidth-1:0] rs1E,
    output logic [regAddrWidth-1:0] rs2E,
    output logic [regAddrWidth-1:0] rdE
);

    logic [6:0]              opcodeD;
    logic [2:0]              funct3D;
    logic                    funct7b5D;
    logic [regAddrWidth-1:0] rs1D;
    logic [regAddrWidth-1:0] rs2D;
    logic [regAddrWidth-1:0] rdD;

    logic                    regWriteD;
    logic [1:0]              resultSrcD;
    logic                    memWriteD;
    logic                    aluSrcD;
    logic [2:0]              immSrcD;
    logic [2:0]              aluOpD;
    logic                    jalrD;
    logic                    jumpD;
    logic                    branchD;
    logic [3:0]              aluControlD;
    logic [dataWidth-1:0]    immExtD;
    logic [dataWidth-1:0]    rd1D;
    logic [dataWidth-1:0]    rd2D;

    // instruction fields
    assign opcodeD   = instrD[6:0];
    assign funct3D   = instrD[14:12];
    assign funct7b5D = instrD[30];
    assign rs1D      = instrD[19:15];
    assign rs2D      = instrD[24:20];
    assign rdD       = instrD[11:7];

    control uControl (
        .opcode     (opcodeD),
        .regWriteD  (regWriteD),
        .resultSrcD (resultSrcD),
        .memWriteD  (memWriteD),
        .aluSrcD    (aluSrcD),
        .immSrcD    (immSrcD),
        .aluOpD     (aluOpD),
        .jalrD      (jalrD),
        .jumpD      (jumpD),
        .branchD    (branchD)
    );

    aluDecoder uAluDecoder (
        .aluOp      (aluOpD),
        .funct3     (funct3D),
        .funct7b5   (funct7b5D),
        .opb5       (opcodeD[5]),   // r-type vs i-type
        .aluControl (aluControlD)
    );

    immExtend #(
        .dataWidth (dataWidth)
    ) uImmExtend (
        .instr  (instrD[31:7]),
        .immSrc (immSrcD),
        .immExt (immExtD)
    );

    regFile #(
        .dataWidth    (dataWidth),
        .regAddrWidth (regAddrWidth)
    ) uRegFile (
        .clk  (clk),
        .rstN (rstN),
        .we   (regWriteW),
        .wa   (rdW),
        .wd   (resultW),
        .ra1  (rs1D),
        .ra2  (rs2D),
        .rd1  (rd1D),
        .rd2  (rd2D)
    );

    decodeExecuteReg #(
        .dataWidth    (dataWidth),
        .regAddrWidth (regAddrWidth)
    ) uDecodeExecuteReg (
        .clk         (clk),
        .rstN        (rstN),
        .flush       (flushE),
        .regWriteD   (regWriteD),
        .resultSrcD  (resultSrcD),
        .memWriteD   (memWriteD),
        .aluSrcD     (aluSrcD),
        .aluControlD (aluControlD),
        .jalrD       (jalrD),
        .jumpD       (jumpD),
        .branchD     (branchD),
        .funct3D     (funct3D),
        .rd1D        (rd1D),
        .rd2D        (rd2D),
        .immExtD     (immExtD),
        .pcD         (pcD),
        .pcPlus4D    (pcPlus4D),
        .rs1D        (rs1D),
        .rs2D        (rs2D),
        .rdD         (rdD),
        .regWriteE   (regWriteE),
        .resultSrcE  (resultSrcE),
        .memWriteE   (memWriteE),
        .aluSrcE     (aluSrcE),
        .aluControlE (aluControlE),
        .jalrE       (jalrE),
        .jumpE       (jumpE),
        .branchE     (branchE),
        .funct3E     (funct3E),
        .rd1E        (rd1E),
        .rd2E        (rd2E),
        .immExtE     (immExtE),
        .pcE         (pcE),
        .pcPlus4E    (pcPlus4E),
        .rs1E        (rs1E),
        .rs2E        (rs2E),
        .rdE         (rdE)
    );

endmodule

/* tbClock.sv */
module tbClock #(
    parameter int period = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;   // 50 percent duty
        end
    end

endmodule

/* decodeStageTb.sv */
module decodeStageTb
    import riscvPkg::*;
();

    localparam int clkPeriod = 40;
    localparam int waitLimit = 4 * clkPeriod;   // time units allowed per edge wait

    logic        clk;
    logic        rstN;
    logic [31:0] instrD;
    logic [31:0] pcD;
    logic [31:0] pcPlus4D;
    logic        flushE;
    logic        regWriteW;
    logic [4:0]  rdW;
    logic [31:0] resultW;
    logic        regWriteE;
    logic [1:0]  resultSrcE;
    logic        memWriteE;
    logic        aluSrcE;
    logic [3:0]  aluControlE;
    logic        jalrE;
    logic        jumpE;
    logic        branchE;
    logic [2:0]  funct3E;
    logic [31:0] rd1E;
    logic [31:0] rd2E;
    logic [31:0] immExtE;
    logic [31:0] pcE;
    logic [31:0] pcPlus4E;
    logic [4:0]  rs1E;
    logic [4:0]  rs2E;
    logic [4:0]  rdE;

    // expected E values one cycle behind the inputs
    logic        expRegWrite;
    logic [1:0]  expResultSrc;
    logic        expMemWrite;
    logic        expAluSrc;
    logic [3:0]  expAluControl;
    logic        expJalr;
    logic        expJump;
    logic        expBranch;
    logic [2:0]  expFunct3;
    logic [31:0] expRd1;
    logic [31:0] expRd2;
    logic [31:0] expImm;
    logic [31:0] expPc;
    logic [31:0] expPcPlus4;
    logic [4:0]  expRs1;
    logic [4:0]  expRs2;
    logic [4:0]  expRd;

    logic [31:0] modelRegs [32];   // reference register file
    integer      seed;
    string       testName;
    int          testErrors;
    int          errorCount;
    int          checkCount;
    int          testsRun;
    int          testsFailed;
    logic [31:0] instr;
    logic [31:0] pc;

    tbClock #(.period(clkPeriod)) uClock (.clk(clk));

    decodeStage #(
        .dataWidth    (32),
        .regAddrWidth (5)
    ) dut (
        .clk         (clk),
        .rstN        (rstN),
        .instrD      (instrD),
        .pcD         (pcD),
        .pcPlus4D    (pcPlus4D),
        .flushE      (flushE),
        .regWriteW   (regWriteW),
        .rdW         (rdW),
        .resultW     (resultW),
        .regWriteE   (regWriteE),
        .resultSrcE  (resultSrcE),
        .memWriteE   (memWriteE),
        .aluSrcE     (aluSrcE),
        .aluControlE (aluControlE),
        .jalrE       (jalrE),
        .jumpE       (jumpE),
        .branchE     (branchE),
        .funct3E     (funct3E),
        .rd1E        (rd1E),
        .rd2E        (rd2E),
        .immExtE     (immExtE),
        .pcE         (pcE),
        .pcPlus4E    (pcPlus4E),
        .rs1E        (rs1E),
        .rs2E        (rs2E),
        .rdE         (rdE)
    );

    // poll until a high then low phase is seen
    task automatic nextNegedge();
        int guard;
        guard = 0;
        while (clk !== 1'b1 && guard < waitLimit) begin
            #1;
            guard++;
        end
        while (clk !== 1'b0 && guard < waitLimit) begin
            #1;
            guard++;
        end
        if (guard >= waitLimit) begin
            $display("timeout: no falling clock edge within %0d time units at %0t",
                     waitLimit, $time);
            $display("=== FAIL ===");
            $finish;
        end
    endtask

    function automatic logic [3:0] arithOp(input logic [2:0] f3, input logic b30,
                                           input logic opb5);
        case (f3)
            3'd0:    return (b30 && opb5) ? aluSub : aluAdd;   // addi never subtracts
            3'd1:    return aluSll;
            3'd2:    return aluSlt;
            3'd3:    return aluSltu;
            3'd4:    return aluXor;
            3'd5:    return b30 ? aluSra : aluSrl;
            3'd6:    return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    function automatic logic [3:0] branchOp(input logic [2:0] f3);
        case (f3[2:1])
            2'b10:   return aluSlt;    // blt bge
            2'b11:   return aluSltu;   // bltu bgeu
            default: return aluSub;    // beq bne and reserved
        endcase
    endfunction

    function automatic logic [31:0] immValue(input logic [31:0] i, input logic [2:0] fmt);
        case (fmt)
            immI:    return {{20{i[31]}}, i[31:20]};
            immS:    return {{20{i[31]}}, i[31:25], i[11:7]};
            immB:    return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
            immU:    return {i[31:12], 12'h000};
            immJ:    return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
            default: return 32'h0;
        endcase
    endfunction

    // x0 reads zero and a same-cycle write shows through
    function automatic logic [31:0] readModel(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return 32'h0;
        end else if (regWriteW && rdW == addr) begin
            return resultW;
        end
        return modelRegs[addr];
    endfunction

    task automatic clearExpected();
        {expRegWrite, expResultSrc, expMemWrite, expAluSrc, expAluControl} = 9'h0;
        {expJalr, expJump, expBranch, expFunct3} = 6'h0;
        {expRd1, expRd2, expImm, expPc, expPcPlus4} = 160'h0;
        {expRs1, expRs2, expRd} = 15'h0;
    endtask

    task automatic modelDecode();
        logic [2:0] fmt;
        fmt = immI;   // control default for r-type and unknown too
        clearExpected();
        expAluControl = arithOp(instrD[14:12], instrD[30], instrD[5]);
        case (instrD[6:0])
            opR: begin
                expRegWrite = 1'b1;
            end
            opI: begin
                expRegWrite = 1'b1;
                expAluSrc   = 1'b1;
            end
            opLoad: begin
                expRegWrite   = 1'b1;
                expResultSrc  = resMem;
                expAluSrc     = 1'b1;
                expAluControl = aluAdd;
            end
            opStore: begin
                expMemWrite   = 1'b1;
                expAluSrc     = 1'b1;
                expAluControl = aluAdd;
                fmt           = immS;
            end
            opBranch: begin
                expBranch     = 1'b1;
                expAluControl = branchOp(instrD[14:12]);
                fmt           = immB;
            end
            opJal, opJalr: begin
                expRegWrite   = 1'b1;
                expResultSrc  = resPc4;
                expAluSrc     = 1'b1;
                expAluControl = aluAdd;
                expJump       = 1'b1;
                expJalr       = (instrD[6:0] == opJalr);
                fmt           = (instrD[6:0] == opJal) ? immJ : immI;
            end
            opLui, opAuipc: begin
                expRegWrite   = 1'b1;
                expAluSrc     = 1'b1;
                expResultSrc  = (instrD[6:0] == opLui) ? resAlu : resAuipc;
                expAluControl = (instrD[6:0] == opLui) ? aluPassB : aluAdd;
                fmt           = immU;
            end
            default: begin
                expRegWrite = 1'b0;   // unknown opcode keeps all enables low
            end
        endcase
        expImm     = immValue(instrD, fmt);
        expFunct3  = instrD[14:12];
        expRs1     = instrD[19:15];
        expRs2     = instrD[24:20];
        expRd      = instrD[11:7];
        expRd1     = readModel(instrD[19:15]);
        expRd2     = readModel(instrD[24:20]);
        expPc      = pcD;
        expPcPlus4 = pcPlus4D;
        if (flushE) begin
            clearExpected();   // bubble
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            testErrors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkOutputs();
        checkValue("regWriteE", 32'(regWriteE), 32'(expRegWrite));
        checkValue("resultSrcE", 32'(resultSrcE), 32'(expResultSrc));
        checkValue("memWriteE", 32'(memWriteE), 32'(expMemWrite));
        checkValue("aluSrcE", 32'(aluSrcE), 32'(expAluSrc));
        checkValue("aluControlE", 32'(aluControlE), 32'(expAluControl));
        checkValue("jalrE", 32'(jalrE), 32'(expJalr));
        checkValue("jumpE", 32'(jumpE), 32'(expJump));
        checkValue("branchE", 32'(branchE), 32'(expBranch));
        checkValue("funct3E", 32'(funct3E), 32'(expFunct3));
        checkValue("rd1E", rd1E, expRd1);
        checkValue("rd2E", rd2E, expRd2);
        checkValue("immExtE", immExtE, expImm);
        checkValue("pcE", pcE, expPc);
        checkValue("pcPlus4E", pcPlus4E, expPcPlus4);
        checkValue("rs1E", 32'(rs1E), 32'(expRs1));
        checkValue("rs2E", 32'(rs2E), 32'(expRs2));
        checkValue("rdE", 32'(rdE), 32'(expRd));
    endtask

    // drive on the falling edge and check one cycle later
    task automatic applyCycle(input logic [31:0] ins, input logic [31:0] pcIn,
                              input logic flush, input logic we, input logic [4:0] wa,
                              input logic [31:0] wd);
        instrD    = ins;
        pcD       = pcIn;
        pcPlus4D  = pcIn + 32'd4;
        flushE    = flush;
        regWriteW = we;
        rdW       = wa;
        resultW   = wd;
        modelDecode();
        if (we && wa != 5'd0) begin
            modelRegs[wa] = wd;   // lands at the coming rising edge
        end
        nextNegedge();
        checkOutputs();
    endtask

    task automatic makeRandomInstr(output logic [31:0] ins, input logic forceNeg);
        logic [31:0] bits;
        logic [6:0]  op;
        int          pick;
        bits = $random(seed);
        pick = $unsigned($random(seed)) % 10;
        case (pick)
            0: op = opR;
            1: op = opI;
            2: op = opLoad;
            3: op = opStore;
            4: op = opBranch;
            5: op = opJal;
            6: op = opJalr;
            7: op = opLui;
            8: op = opAuipc;
            default: begin
                case ($unsigned($random(seed)) % 4)
                    0:       op = 7'b0000000;
                    1:       op = 7'b1111111;
                    2:       op = 7'b0001111;   // fence is not decoded here
                    default: op = 7'b1110011;   // system
                endcase
            end
        endcase
        if (forceNeg) begin
            bits[31] = 1'b1;
        end
        // legal funct7 for r-type and immediate shifts
        if (op == opR || (op == opI && bits[13:12] == 2'b01)) begin
            bits[31:25] = bits[30] ? 7'b0100000 : 7'b0000000;
            if (op == opI && bits[14:12] == 3'b001) begin
                bits[31:25] = 7'b0000000;   // slli
            end
        end
        ins = {bits[31:7], op};
    endtask

    task automatic startTest(input string name);
        testName   = name;
        testErrors = 0;
    endtask

    task automatic endTest();
        testsRun++;
        if (testErrors == 0) begin
            $display("test %s: ok", testName);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", testName, testErrors);
        end
    endtask

    initial begin
        seed        = 32'hd6c0;
        errorCount  = 0;
        checkCount  = 0;
        testsRun    = 0;
        testsFailed = 0;
        rstN        = 1'b0;
        instrD      = 32'h0;
        pcD         = 32'h0;
        pcPlus4D    = 32'h0;
        flushE      = 1'b0;
        regWriteW   = 1'b0;
        rdW         = 5'd0;
        resultW     = 32'h0;
        for (int r = 0; r < 32; r++) begin
            modelRegs[r] = 32'h0;
        end
        repeat (8) nextNegedge();   // reset held 8 cycles
        rstN = 1'b1;

        startTest("reset outputs zero");
        clearExpected();
        checkOutputs();
        endTest();

        startTest("random decode");
        for (int n = 0; n < 300; n++) begin
            makeRandomInstr(instr, 1'b0);
            pc = $random(seed) & 32'hffff_fffc;
            applyCycle(instr, pc, 1'b0, 1'($random(seed)), 5'($random(seed)), $random(seed));
        end
        endTest();

        startTest("negative immediates");
        for (int n = 0; n < 60; n++) begin
            makeRandomInstr(instr, 1'b1);
            applyCycle(instr, 32'h100 + 32'(n * 4), 1'b0, 1'b0, 5'd0, 32'h0);
        end
        endTest();

        startTest("writeback and read");
        for (int n = 0; n < 40; n++) begin
            pc = $random(seed);   // value to write
            instr = {7'b0, 5'($random(seed)), 5'(n % 32), 3'b000, 5'd1, opR};
            applyCycle(instr, 32'h0, 1'b0, 1'b1, 5'(n % 32), pc);   // rs1 forwarded
        end
        for (int r = 0; r < 32; r++) begin
            instr = {7'b0, 5'(31 - r), 5'(r), 3'b000, 5'd2, opR};
            applyCycle(instr, 32'h0, 1'b0, 1'b0, 5'd0, 32'h0);
        end
        instr = {7'b0, 5'd0, 5'd0, 3'b000, 5'd3, opR};
        applyCycle(instr, 32'h0, 1'b0, 1'b1, 5'd0, 32'hffff_ffff);   // x0 write dropped
        applyCycle(instr, 32'h0, 1'b0, 1'b0, 5'd0, 32'h0);
        endTest();

        startTest("flush bubble");
        for (int n = 0; n < 30; n++) begin
            makeRandomInstr(instr, 1'b0);
            applyCycle(instr, 32'h2000 + 32'(n * 4), (n % 2) == 0, 1'b0, 5'd0, 32'h0);
        end
        endTest();

        startTest("back to back fields");
        pc = $random(seed) & 32'hffff_fffc;
        for (int n = 0; n < 40; n++) begin
            makeRandomInstr(instr, 1'b0);
            applyCycle(instr, pc, 1'b0, 1'b0, 5'd0, 32'h0);
            pc = pc + 32'd4;
        end
        endTest();

        $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
                 testsRun, testsFailed, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* all.f */
riscvPkg.sv
control.sv
aluDecoder.sv
immExtend.sv
regFile.sv
decodeExecuteReg.sv
decodeStage.sv
tbClock.sv
decodeStageTb.sv

/* Makefile */
TOOL     := verilator
TOP      := decodeStageTb
FILELIST := all.f
FLAGS    := --binary --timing --top-module $(TOP)
BUILD    := obj_dir
LOG      := sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
